//--- sim.f
rtl/cpu_pkg.sv
rtl/stage_reg.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/hazard_unit.sv
rtl/alu.sv
rtl/datapath.sv
verif/tb_clock.sv
verif/tb_datapath.sv

//--- run.sh
#!/bin/sh
# build and run; the exit status is the simulation result
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_datapath -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1

//--- verif/tb_datapath.sv
`timescale 1ns/1ps

module tb_datapath;
    import cpu_pkg::*;

    logic  clk, arst_n, rst_req;
    logic  i_read, d_read, d_write, out_valid, is_halted;
    word_t i_data, d_rdata, i_addr, d_addr, d_wdata, output_port, num_inst;

    word_t imem [256];
    word_t dmem [256];
    word_t prog [$];
    word_t exp_wwd [$];
    word_t exp_st_addr [$];
    word_t exp_st_data [$];
    int    exp_count;
    int    budget_cycles = 0;
    int    cycles = 0;
    logic  halt_seen;
    logic [31:0] lcg_state = 32'h2261_a5a3;

    tb_clock i_clock (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

    datapath i_dut (
        .clk(clk), .arst_n(arst_n), .i_data(i_data), .d_rdata(d_rdata),
        .i_read(i_read), .i_addr(i_addr), .d_read(d_read), .d_write(d_write),
        .d_addr(d_addr), .d_wdata(d_wdata), .output_port(output_port),
        .out_valid(out_valid), .num_inst(num_inst), .is_halted(is_halted)
    );

    // memories answer in the same cycle
    assign i_data  = imem[i_addr[7:0]];
    assign d_rdata = dmem[d_addr[7:0]];

    always @(posedge clk) begin
        if (d_write) dmem[d_addr[7:0]] <= d_wdata;
    end

    function automatic logic [7:0] rnd8();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic word_t fill_word(input logic [7:0] a);
        return {a ^ 8'h3c, ~a};
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input reg_idx_t rs,
                                    input reg_idx_t rt, input reg_idx_t rd);
        return {op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic word_t enc_i(input logic [3:0] op, input reg_idx_t rs,
                                    input reg_idx_t rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // sequential ISA model with one instruction per step
    task automatic run_model();
        word_t regs [4];
        word_t mem [256];
        word_t pc, instr, a, b, imm, addr, next_pc;
        int    steps;
        logic  done;
        regs = '{default: '0};
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i[7:0]);
        pc = '0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 1000) begin
            instr   = imem[pc[7:0]];
            a       = regs[instr[11:10]];
            b       = regs[instr[9:8]];
            imm     = {{8{instr[7]}}, instr[7:0]};
            addr    = a + imm;
            next_pc = pc + 16'd1;
            steps++;
            case (instr[15:12])
                op_adi: regs[instr[9:8]] = a + imm;
                op_lwd: regs[instr[9:8]] = mem[addr[7:0]];
                op_swd: begin
                    mem[addr[7:0]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                op_bne: if (a != b) next_pc = pc + 16'd1 + imm;
                op_beq: if (a == b) next_pc = pc + 16'd1 + imm;
                op_jmp: next_pc = {next_pc[15:12], instr[11:0]};
                default: begin
                    case (instr[5:0])
                        fn_add: regs[instr[7:6]] = a + b;
                        fn_sub: regs[instr[7:6]] = a - b;
                        fn_and: regs[instr[7:6]] = a & b;
                        fn_orr: regs[instr[7:6]] = a | b;
                        fn_wwd: exp_wwd.push_back(a);
                        default: done = 1'b1;   // hlt
                    endcase
                end
            endcase
            pc = next_pc;
        end
        exp_count = steps;
        budget_cycles += steps;
    endtask

    task automatic run_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_r(fn_hlt, 2'd0, 2'd0, 2'd0);
            dmem[i] = fill_word(i[7:0]);
        end
        foreach (prog[i]) imem[i] = prog[i];
        run_model();
        rst_req = 1'b1;
        @(negedge clk);
        rst_req = 1'b0;
        @(posedge arst_n);
        assert (!d_read && !d_write && !out_valid && !is_halted && i_read
                && num_inst == 0 && i_addr == 0)
        else fail_now("outputs not in their reset state after reset");
        while (!is_halted) @(negedge clk);
        repeat (4) @(negedge clk);   // hlt retires and nothing may follow
        assert (num_inst == exp_count)
        else fail_now($sformatf("Mismatch num_inst: got %h expected %h",
                                num_inst, exp_count[15:0]));
        assert (exp_wwd.size() == 0) else fail_now("WWD outputs missing at halt");
        assert (exp_st_addr.size() == 0) else fail_now("stores missing at halt");
        prog.delete();
    endtask

    always @(negedge clk) begin
        if (!arst_n) begin
            halt_seen = 1'b0;
        end else begin
            if (out_valid) begin
                assert (!halt_seen) else fail_now("WWD output after halt");
                assert (exp_wwd.size() > 0) else fail_now("unexpected WWD output");
                assert (output_port == exp_wwd[0])
                else fail_now($sformatf("Mismatch output_port: got %h expected %h",
                                        output_port, exp_wwd[0]));
                void'(exp_wwd.pop_front());
            end
            if (d_write) begin
                assert (exp_st_addr.size() > 0) else fail_now("unexpected store");
                assert (d_addr == exp_st_addr[0])
                else fail_now($sformatf("Mismatch d_addr: got %h expected %h",
                                        d_addr, exp_st_addr[0]));
                assert (d_wdata == exp_st_data[0])
                else fail_now($sformatf("Mismatch d_wdata: got %h expected %h",
                                        d_wdata, exp_st_data[0]));
                void'(exp_st_addr.pop_front());
                void'(exp_st_data.pop_front());
            end
            if (halt_seen) begin
                assert (is_halted) else fail_now("is_halted dropped before reset");
                assert (!i_read) else fail_now("fetch still active after halt");
            end
            if (is_halted) halt_seen = 1'b1;
        end
    end

    // watchdog allows eight cycles per modelled instruction plus margin
    always @(negedge clk) begin
        cycles++;
        if (cycles > budget_cycles * 8 + 200) begin
            fail_now("timeout, the core never halted");
        end
    end

    initial begin
        rst_req = 1'b0;
        halt_seen = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_r(fn_hlt, 2'd0, 2'd0, 2'd0);
            dmem[i] = fill_word(i[7:0]);
        end

        // dependent chain with each result written out at once
        prog.push_back(enc_i(op_adi, 2'd0, 2'd1, rnd8()));
        prog.push_back(enc_r(fn_wwd, 2'd1, 2'd0, 2'd0));
        prog.push_back(enc_i(op_adi, 2'd1, 2'd2, rnd8()));
        prog.push_back(enc_r(fn_wwd, 2'd2, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_add, 2'd1, 2'd2, 2'd3));
        prog.push_back(enc_r(fn_wwd, 2'd3, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_sub, 2'd3, 2'd2, 2'd1));
        prog.push_back(enc_r(fn_wwd, 2'd1, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_and, 2'd3, 2'd1, 2'd2));
        prog.push_back(enc_r(fn_wwd, 2'd2, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_orr, 2'd2, 2'd1, 2'd3));
        prog.push_back(enc_r(fn_wwd, 2'd3, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_hlt, 2'd0, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_wwd, 2'd1, 2'd0, 2'd0));   // must never appear
        run_program();

        // store, load, use right away
        prog.push_back(enc_i(op_adi, 2'd0, 2'd1, 8'h20 | (rnd8() & 8'h0f)));
        prog.push_back(enc_i(op_adi, 2'd0, 2'd2, rnd8()));
        prog.push_back(enc_i(op_swd, 2'd1, 2'd2, 8'd0));
        prog.push_back(enc_i(op_lwd, 2'd1, 2'd3, 8'd0));
        prog.push_back(enc_r(fn_wwd, 2'd3, 2'd0, 2'd0));
        prog.push_back(enc_i(op_lwd, 2'd1, 2'd2, 8'd1));
        prog.push_back(enc_r(fn_add, 2'd2, 2'd2, 2'd3));
        prog.push_back(enc_r(fn_wwd, 2'd3, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_hlt, 2'd0, 2'd0, 2'd0));
        run_program();

        // taken and untaken branches, then a jump
        prog.push_back(enc_i(op_adi, 2'd0, 2'd1, rnd8() | 8'h01));
        prog.push_back(enc_i(op_adi, 2'd1, 2'd2, 8'd0));
        prog.push_back(enc_i(op_beq, 2'd1, 2'd2, 8'd2));    // taken
        prog.push_back(enc_i(op_adi, 2'd0, 2'd3, 8'h11));
        prog.push_back(enc_r(fn_wwd, 2'd3, 2'd0, 2'd0));    // skipped
        prog.push_back(enc_i(op_bne, 2'd1, 2'd2, 8'd1));    // not taken
        prog.push_back(enc_r(fn_wwd, 2'd1, 2'd0, 2'd0));
        prog.push_back(enc_i(op_bne, 2'd1, 2'd0, 8'd2));    // taken
        prog.push_back(enc_r(fn_wwd, 2'd0, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_wwd, 2'd0, 2'd0, 2'd0));
        prog.push_back(enc_i(op_beq, 2'd1, 2'd0, 8'd1));    // not taken
        prog.push_back({op_jmp, 12'd14});
        prog.push_back(enc_r(fn_wwd, 2'd1, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_hlt, 2'd0, 2'd0, 2'd0));
        prog.push_back(enc_i(op_adi, 2'd1, 2'd3, rnd8()));
        prog.push_back(enc_r(fn_wwd, 2'd3, 2'd0, 2'd0));
        prog.push_back(enc_r(fn_hlt, 2'd0, 2'd0, 2'd0));
        run_program();

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period = 20
) (
    input  logic rst_req,   // pulse to start another reset
    output logic clk,
    output logic arst_n
);

    initial clk = 1'b0;
    always #(half_period) clk = ~clk;

    // two rising edges in reset, release on the falling edge after them
    initial begin
        arst_n = 1'b0;
        forever begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;
            @(posedge rst_req);
            arst_n = 1'b0;
        end
    end

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic           clk,
    input  logic           arst_n,
    input  cpu_pkg::word_t i_data,
    input  cpu_pkg::word_t d_rdata,
    output logic           i_read,
    output cpu_pkg::word_t i_addr,
    output logic           d_read,
    output logic           d_write,
    output cpu_pkg::word_t d_addr,
    output cpu_pkg::word_t d_wdata,
    output cpu_pkg::word_t output_port,
    output logic           out_valid,
    output cpu_pkg::word_t num_inst,
    output logic           is_halted
);
    import cpu_pkg::*;

    word_t    pc;
    word_t    pc_plus1;
    logic     halt_fetch;   // hlt seen in decode
    logic     halted_q;

    if_id_t   if_id_d, if_id_q;
    id_ex_t   id_ex_d, id_ex_q;
    ex_mem_t  ex_mem_d, ex_mem_q;
    mem_wb_t  mem_wb_d, mem_wb_q;

    ctrl_t    dec_ctrl;
    alu_op_t  dec_alu_op;
    word_t    dec_imm, dec_target;
    reg_idx_t dec_rd, id_rs, id_rt;
    logic     dec_redirect, dec_uses_rs, dec_uses_rt;

    logic     id_live, id_halt, is_branch, redirect;
    logic     stall, flush_fetch;
    logic [1:0] id_fwd_a, id_fwd_b, ex_fwd_a, ex_fwd_b;

    word_t    rf_rdata1, rf_rdata2;
    word_t    id_a, id_b;
    word_t    ex_a, ex_b, alu_b, alu_y;
    word_t    wb_data;

    function automatic word_t fwd_mux(input logic [1:0] sel,
                                      input word_t      from_mem,
                                      input word_t      from_wb,
                                      input word_t      from_reg);
        case (sel)
            fwd_mem: return from_mem;
            fwd_wb:  return from_wb;
            default: return from_reg;
        endcase
    endfunction

    // fetch
    assign pc_plus1 = pc + 1'b1;
    assign i_addr   = pc;
    assign i_read   = !halt_fetch && !id_halt;   // drop the slot behind hlt

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (i_read && !stall) begin
            pc <= flush_fetch ? dec_target : pc_plus1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halt_fetch <= 1'b0;
        end else if (id_halt) begin
            halt_fetch <= 1'b1;
        end
    end

    assign if_id_d = '{valid: i_read, pc_plus1: pc_plus1, instr: i_data};

    stage_reg #(.payload_t(if_id_t)) i_if_id (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (stall),
        .flush  (flush_fetch),
        .d      (if_id_d),
        .q      (if_id_q)
    );

    // decode
    assign id_rs     = if_id_q.instr[11:10];
    assign id_rt     = if_id_q.instr[9:8];
    assign id_live   = if_id_q.valid;
    assign id_halt   = id_live && dec_ctrl.is_halt;
    assign is_branch = id_live && (if_id_q.instr[15:12] == op_bne ||
                                   if_id_q.instr[15:12] == op_beq);
    assign redirect  = id_live && dec_redirect;

    reg_file i_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .rs     (id_rs),
        .rt     (id_rt),
        .rd     (mem_wb_q.rd),
        .wdata  (wb_data),
        .we     (mem_wb_q.ctrl.reg_write),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    assign id_a = fwd_mux(id_fwd_a, ex_mem_q.alu_result, wb_data, rf_rdata1);
    assign id_b = fwd_mux(id_fwd_b, ex_mem_q.alu_result, wb_data, rf_rdata2);

    decoder i_decoder (
        .instr    (if_id_q.instr),
        .pc_plus1 (if_id_q.pc_plus1),
        .op_a     (id_a),
        .op_b     (id_b),
        .ctrl     (dec_ctrl),
        .alu_op   (dec_alu_op),
        .imm      (dec_imm),
        .rd       (dec_rd),
        .redirect (dec_redirect),
        .target   (dec_target),
        .uses_rs  (dec_uses_rs),
        .uses_rt  (dec_uses_rt)
    );

    hazard_unit i_hazard_unit (
        .id_rs       (id_rs),
        .id_rt       (id_rt),
        .uses_rs     (id_live && dec_uses_rs),
        .uses_rt     (id_live && dec_uses_rt),
        .is_branch   (is_branch),
        .redirect    (redirect),
        .ex          (id_ex_q),
        .mem         (ex_mem_q),
        .wb          (mem_wb_q),
        .stall       (stall),
        .flush_fetch (flush_fetch),
        .id_fwd_a    (id_fwd_a),
        .id_fwd_b    (id_fwd_b),
        .ex_fwd_a    (ex_fwd_a),
        .ex_fwd_b    (ex_fwd_b)
    );

    assign id_ex_d = '{ctrl:   id_live ? dec_ctrl : '0,
                       alu_op: dec_alu_op,
                       op_a:   id_a,
                       op_b:   id_b,
                       imm:    dec_imm,
                       rs:     id_rs,
                       rt:     id_rt,
                       rd:     dec_rd};

    stage_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (1'b0),
        .flush  (stall),   // bubble while decode waits
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    // execute
    assign ex_a  = fwd_mux(ex_fwd_a, ex_mem_q.alu_result, wb_data, id_ex_q.op_a);
    assign ex_b  = fwd_mux(ex_fwd_b, ex_mem_q.alu_result, wb_data, id_ex_q.op_b);
    assign alu_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : ex_b;

    alu i_alu (
        .a  (ex_a),
        .b  (alu_b),
        .op (id_ex_q.alu_op),
        .y  (alu_y)
    );

    assign ex_mem_d = '{ctrl:       id_ex_q.ctrl,
                        alu_result: alu_y,
                        store_data: ex_b,
                        rd:         id_ex_q.rd};

    stage_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (1'b0),
        .flush  (1'b0),
        .d      (ex_mem_d),
        .q      (ex_mem_q)
    );

    // memory, data answers in the same cycle
    assign d_read  = ex_mem_q.ctrl.mem_read;
    assign d_write = ex_mem_q.ctrl.mem_write;
    assign d_addr  = ex_mem_q.alu_result;
    assign d_wdata = ex_mem_q.store_data;

    assign mem_wb_d = '{ctrl:       ex_mem_q.ctrl,
                        alu_result: ex_mem_q.alu_result,
                        mem_data:   d_rdata,
                        rd:         ex_mem_q.rd};

    stage_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk    (clk),
        .arst_n (arst_n),
        .hold   (1'b0),
        .flush  (1'b0),
        .d      (mem_wb_d),
        .q      (mem_wb_q)
    );

    // write-back
    assign wb_data     = mem_wb_q.ctrl.mem_to_reg ? mem_wb_q.mem_data : mem_wb_q.alu_result;
    assign out_valid   = mem_wb_q.ctrl.is_wwd;
    assign output_port = mem_wb_q.alu_result;   // wwd carries rs here
    assign is_halted   = halted_q || mem_wb_q.ctrl.is_halt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted_q <= 1'b0;
            num_inst <= '0;
        end else begin
            if (mem_wb_q.ctrl.is_halt) begin
                halted_q <= 1'b1;   // sticky until reset
            end
            if (mem_wb_q.ctrl.valid) begin
                num_inst <= num_inst + 1'b1;
            end
        end
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   y
);
    import cpu_pkg::*;

    // 16-bit wrap, no flags
    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_and: y = a & b;
            alu_or:  y = a | b;
            default: y = b;   // pass-b and spare codes
        endcase
    end

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  cpu_pkg::reg_idx_t id_rs,
    input  cpu_pkg::reg_idx_t id_rt,
    input  logic              uses_rs,
    input  logic              uses_rt,
    input  logic              is_branch,
    input  logic              redirect,
    input  cpu_pkg::id_ex_t   ex,
    input  cpu_pkg::ex_mem_t  mem,
    input  cpu_pkg::mem_wb_t  wb,
    output logic              stall,
    output logic              flush_fetch,
    output logic [1:0]        id_fwd_a,
    output logic [1:0]        id_fwd_b,
    output logic [1:0]        ex_fwd_a,
    output logic [1:0]        ex_fwd_b
);
    import cpu_pkg::*;

    logic dep_ex;    // decode reads what execute writes
    logic dep_mem;   // decode reads what memory writes

    // nearest writer wins; a load in memory has no result yet
    function automatic logic [1:0] fwd_sel(input reg_idx_t src,
                                           input ex_mem_t  m,
                                           input mem_wb_t  w);
        if (m.ctrl.reg_write && !m.ctrl.mem_read && m.rd == src) begin
            return fwd_mem;
        end else if (w.ctrl.reg_write && w.rd == src) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    assign dep_ex  = (uses_rs && id_rs == ex.rd) || (uses_rt && id_rt == ex.rd);
    assign dep_mem = (uses_rs && id_rs == mem.rd) || (uses_rt && id_rt == mem.rd);

    // load-use, plus branches that compare before the operand exists
    assign stall = (dep_ex && ex.ctrl.mem_read)
                || (is_branch && dep_ex && ex.ctrl.reg_write)
                || (is_branch && dep_mem && mem.ctrl.mem_read);

    assign flush_fetch = redirect && !stall;   // compare is stale while stalled

    assign id_fwd_a = fwd_sel(id_rs, mem, wb);
    assign id_fwd_b = fwd_sel(id_rt, mem, wb);
    assign ex_fwd_a = fwd_sel(ex.rs, mem, wb);
    assign ex_fwd_b = fwd_sel(ex.rt, mem, wb);

endmodule

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::word_t    pc_plus1,
    input  cpu_pkg::word_t    op_a,      // forwarded rs value
    input  cpu_pkg::word_t    op_b,      // forwarded rt value
    output cpu_pkg::ctrl_t    ctrl,
    output cpu_pkg::alu_op_t  alu_op,
    output cpu_pkg::word_t    imm,
    output cpu_pkg::reg_idx_t rd,
    output logic              redirect,
    output cpu_pkg::word_t    target,
    output logic              uses_rs,
    output logic              uses_rt
);
    import cpu_pkg::*;

    logic [3:0] opcode;
    logic [5:0] func;
    word_t      imm_sx;

    assign opcode = instr[15:12];
    assign func   = instr[5:0];
    assign imm_sx = {{(word_size-8){instr[7]}}, instr[7:0]};

    always_comb begin
        ctrl       = '0;
        ctrl.valid = 1'b1;
        alu_op     = alu_pass_b;
        imm        = imm_sx;
        rd         = instr[7:6];
        redirect   = 1'b0;
        target     = pc_plus1 + imm_sx;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;

        case (opcode)
            op_rtype: begin
                imm     = '0;   // low byte is rd/func here, wwd adds zero
                uses_rs = 1'b1;
                case (func)
                    fn_add: begin
                        ctrl.reg_write = 1'b1;
                        alu_op         = alu_add;
                        uses_rt        = 1'b1;
                    end
                    fn_sub: begin
                        ctrl.reg_write = 1'b1;
                        alu_op         = alu_sub;
                        uses_rt        = 1'b1;
                    end
                    fn_and: begin
                        ctrl.reg_write = 1'b1;
                        alu_op         = alu_and;
                        uses_rt        = 1'b1;
                    end
                    fn_orr: begin
                        ctrl.reg_write = 1'b1;
                        alu_op         = alu_or;
                        uses_rt        = 1'b1;
                    end
                    fn_wwd: begin
                        ctrl.is_wwd      = 1'b1;
                        ctrl.alu_src_imm = 1'b1;
                        alu_op           = alu_add;   // rs + 0
                    end
                    fn_hlt: begin
                        ctrl.is_halt = 1'b1;
                        uses_rs      = 1'b0;
                    end
                    default: begin
                        ctrl.valid = 1'b0;   // unknown func, dropped
                        uses_rs    = 1'b0;
                    end
                endcase
            end
            op_adi: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                alu_op           = alu_add;
                rd               = instr[9:8];
                uses_rs          = 1'b1;
            end
            op_lwd: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                alu_op           = alu_add;   // address
                rd               = instr[9:8];
                uses_rs          = 1'b1;
            end
            op_swd: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                alu_op           = alu_add;
                uses_rs          = 1'b1;
                uses_rt          = 1'b1;      // store data
            end
            op_bne: begin
                uses_rs  = 1'b1;
                uses_rt  = 1'b1;
                redirect = (op_a != op_b);
            end
            op_beq: begin
                uses_rs  = 1'b1;
                uses_rt  = 1'b1;
                redirect = (op_a == op_b);
            end
            op_jmp: begin
                redirect = 1'b1;
                target   = {pc_plus1[15:12], instr[11:0]};
            end
            default: ctrl.valid = 1'b0;
        endcase
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic             clk,
    input  logic             arst_n,
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    input  cpu_pkg::reg_idx_t rd,
    input  cpu_pkg::word_t   wdata,
    input  logic             we,
    output cpu_pkg::word_t   rdata1,
    output cpu_pkg::word_t   rdata2
);
    import cpu_pkg::*;

    word_t regs [4];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (we) begin
            regs[rd] <= wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rdata1 = (we && rd == rs) ? wdata : regs[rs];
    assign rdata2 = (we && rd == rt) ? wdata : regs[rt];

endmodule

//--- rtl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload is a bubble: valid and control bits clear
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;   // flush wins over hold
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int word_size = 16;

    typedef logic [1:0]           reg_idx_t;
    typedef logic [word_size-1:0] word_t;

    // opcodes in instr[15:12]
    localparam logic [3:0] op_bne   = 4'd0;
    localparam logic [3:0] op_beq   = 4'd1;
    localparam logic [3:0] op_adi   = 4'd4;
    localparam logic [3:0] op_lwd   = 4'd7;
    localparam logic [3:0] op_swd   = 4'd8;
    localparam logic [3:0] op_jmp   = 4'd9;
    localparam logic [3:0] op_rtype = 4'd15;

    // function codes, r-type only
    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_wwd = 6'd28;
    localparam logic [5:0] fn_hlt = 6'd29;

    // operand forwarding sources
    localparam logic [1:0] fwd_reg = 2'd0; // register file or stage payload
    localparam logic [1:0] fwd_wb  = 2'd1;
    localparam logic [1:0] fwd_mem = 2'd2;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic alu_src_imm;
        logic is_wwd;
        logic is_halt;
        logic valid;       // counts toward num_inst at write-back
    } ctrl_t;

    typedef struct packed {
        logic  valid;      // slot holds a real fetch
        word_t pc_plus1;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        alu_op_t  alu_op;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;
        word_t    mem_data;
        reg_idx_t rd;
    } mem_wb_t;

endpackage
